// ==== Bender.yml ====
package:
  name: audio_sound

export_include_dirs:
  - hw

sources:
  - hw/audio_pkg.sv
  - hw/mix_if.sv
  - hw/sound_port_decode.sv
  - hw/sound_latch.sv
  - hw/audio_mixer.sv
  - hw/audio_top.sv
  - target: test
    files:
      - verification/tb_clock.sv
      - verification/audio_tb.sv

// ==== hw/audio_mixer.sv ====
`include "audio_params.svh"

module audio_mixer (
  input  logic               clk_28mhz,
  input  logic               rst,
  mix_if.sink                mix,
  output audio_pkg::sample_t audio_l,
  output audio_pkg::sample_t audio_r
);

  // largest magnitude the compressor can produce
  localparam int COMP_MAX = `COMP_X * `COMP_A + (32768 - `COMP_X) / `COMP_F;

  // stage one registers
  audio_pkg::sample_t pre_l;
  audio_pkg::sample_t pre_r;

  // one side of the pre-sum, wraps modulo 2^16
  // AY scaled by 16, SAA, covox and beeper by 64
  function automatic audio_pkg::sample_t presum(
    input logic [`TS_W-1:0]  ts,
    input logic [`SAA_W-1:0] saa,
    input logic [`SAA_W-1:0] covox,
    input logic              beeper
  );
    logic [15:0] sum;
    sum = {ts, 4'b0000}
        + {2'b00, saa, 6'b000000}
        + {2'b00, covox, 6'b000000}
        + {9'b000000000, beeper, 6'b000000};
    return audio_pkg::sample_t'(sum);
  endfunction

  // soft-knee compressor on the magnitude
  // gain A below the knee, slope 1/F above it
  function automatic audio_pkg::sample_t compress(input audio_pkg::sample_t x);
    logic [16:0] mag;
    logic [16:0] res;
    // 17 bits so that -32768 gives a clean 32768
    mag = x[15] ? (~{x[15], x} + 17'd1) : {1'b0, x};
    if (mag < 17'(`COMP_X)) begin
      res = 17'(mag * `COMP_A);
    end else begin
      res = 17'((mag - 17'(`COMP_X)) / `COMP_F + `COMP_X * `COMP_A);
    end
    // sign back, result wraps like the pre-sum
    return x[15] ? audio_pkg::sample_t'(~res[15:0] + 16'd1)
                 : audio_pkg::sample_t'(res[15:0]);
  endfunction

  // magnitude of an output sample
  function automatic int mag_of(input audio_pkg::sample_t s);
    return (s < 0) ? -int'(s) : int'(s);
  endfunction

  // stage one, sum of all sources per side
  always_ff @(posedge clk_28mhz) begin
    if (rst) begin
      pre_l <= '0;
      pre_r <= '0;
    end else begin
      pre_l <= presum(mix.ts_l, mix.saa_l, mix.covox, mix.beeper);
      pre_r <= presum(mix.ts_r, mix.saa_r, mix.covox, mix.beeper);
    end
  end

  // stage two, compress and register the outputs
  always_ff @(posedge clk_28mhz) begin
    if (rst) begin
      audio_l <= '0;
      audio_r <= '0;
    end else begin
      audio_l <= compress(pre_l);
      audio_r <= compress(pre_r);
    end
  end

  // outputs stay inside the compressor range
  assert property (@(posedge clk_28mhz) disable iff (rst)
    mag_of(audio_l) <= COMP_MAX && mag_of(audio_r) <= COMP_MAX);

endmodule

// ==== hw/audio_params.svh ====
`ifndef AUDIO_PARAMS_SVH
`define AUDIO_PARAMS_SVH

// output sample width, signed
`define AUDIO_W 16

// channel widths of the external sound chips
// AY pair (TurboSound) delivers 12 bits per side
`define TS_W 12
// SAA channel, also used for the covox byte
`define SAA_W 8

// low address byte of the sound related I/O ports
`define BEEPER_PORT 8'hFE
`define COVOX_PORT 8'hFB
`define SAA_PORT 8'hFF

// data bit of the FE write that drives the beeper
`define BEEPER_BIT 4

// soft-knee compressor
// slope divisor above the knee
`define COMP_F 4
// gain below the knee
`define COMP_A 2
// knee level, 32767*(F-1)/(F*A-1)+1
`define COMP_X 14044

`endif

// ==== hw/audio_pkg.sv ====
`include "audio_params.svh"

package audio_pkg;

  // decoded I/O write operation, one per cycle
  // port_none means no write this cycle
  typedef enum logic [2:0] {
    port_none,
    port_beeper,
    port_covox,
    port_saa,
    port_ts
  } port_op_t;

  // mixed output sample, two's complement
  typedef logic signed [`AUDIO_W-1:0] sample_t;

endpackage

// ==== hw/audio_top.sv ====
`include "audio_params.svh"

module audio_top (
  input  logic               clk_28mhz,
  input  logic               rst,
  input  logic [15:0]        cpu_addr,
  input  logic [7:0]         cpu_data,
  input  logic               iorq_n,
  input  logic               wr_n,
  input  logic [`TS_W-1:0]   ts_l,
  input  logic [`TS_W-1:0]   ts_r,
  input  logic [`SAA_W-1:0]  saa_l,
  input  logic [`SAA_W-1:0]  saa_r,
  output logic               saa_wr_n,
  output logic               ts_we,
  output logic               ts_bc,
  output audio_pkg::sample_t audio_l,
  output audio_pkg::sample_t audio_r
);

  // decoder to latch strobe and data
  audio_pkg::port_op_t wr_op;
  logic [7:0]          wr_data;

  // latched levels toward the mixer
  mix_if mix ();

  // bus decode and external chip strobes
  sound_port_decode u_decode (
    .clk_28mhz (clk_28mhz),
    .rst       (rst),
    .cpu_addr  (cpu_addr),
    .cpu_data  (cpu_data),
    .iorq_n    (iorq_n),
    .wr_n      (wr_n),
    .saa_wr_n  (saa_wr_n),
    .ts_we     (ts_we),
    .ts_bc     (ts_bc),
    .wr_op     (wr_op),
    .wr_data   (wr_data)
  );

  // beeper, covox and channel resampling
  sound_latch u_latch (
    .clk_28mhz (clk_28mhz),
    .rst       (rst),
    .wr_op     (wr_op),
    .wr_data   (wr_data),
    .ts_l      (ts_l),
    .ts_r      (ts_r),
    .saa_l     (saa_l),
    .saa_r     (saa_r),
    .mix       (mix.source)
  );

  // sum and compressor pipeline
  audio_mixer u_mixer (
    .clk_28mhz (clk_28mhz),
    .rst       (rst),
    .mix       (mix.sink),
    .audio_l   (audio_l),
    .audio_r   (audio_r)
  );

endmodule

// ==== hw/mix_if.sv ====
`include "audio_params.svh"

// channel levels from the sound latch to the mixer
// plain levels, the mixer samples them every cycle
interface mix_if;

  // AY pair output, already in the clk_28mhz domain
  logic [`TS_W-1:0] ts_l;
  logic [`TS_W-1:0] ts_r;

  // SAA output, resampled from its own clock
  logic [`SAA_W-1:0] saa_l;
  logic [`SAA_W-1:0] saa_r;

  // covox byte, same on both sides
  logic [`SAA_W-1:0] covox;

  // beeper bit from port FE
  logic beeper;

  // latch side
  modport source (
    output ts_l, ts_r, saa_l, saa_r, covox, beeper
  );

  // mixer side
  modport sink (
    input ts_l, ts_r, saa_l, saa_r, covox, beeper
  );

endinterface

// ==== hw/sound_latch.sv ====
`include "audio_params.svh"

module sound_latch (
  input  logic                clk_28mhz,
  input  logic                rst,
  input  audio_pkg::port_op_t wr_op,
  input  logic [7:0]          wr_data,
  input  logic [`TS_W-1:0]    ts_l,
  input  logic [`TS_W-1:0]    ts_r,
  input  logic [`SAA_W-1:0]   saa_l,
  input  logic [`SAA_W-1:0]   saa_r,
  mix_if.source               mix
);

  // beeper and covox registers
  always_ff @(posedge clk_28mhz) begin
    if (rst) begin
      mix.beeper <= 1'b0;
      mix.covox  <= '0;
    end else begin
      case (wr_op)
        // only the beeper bit of FE matters here, border is elsewhere
        audio_pkg::port_beeper: mix.beeper <= wr_data[`BEEPER_BIT];
        audio_pkg::port_covox:  mix.covox  <= wr_data;
        // port_saa and port_ts go to the external chips
        default: ;
      endcase
    end
  end

  // resample the external chip outputs every cycle
  // SAA runs on its own clock, so this is the crossing into clk_28mhz
  // output levels change slowly, one flop is enough for audio
  always_ff @(posedge clk_28mhz) begin
    if (rst) begin
      mix.ts_l  <= '0;
      mix.ts_r  <= '0;
      mix.saa_l <= '0;
      mix.saa_r <= '0;
    end else begin
      mix.ts_l  <= ts_l;
      mix.ts_r  <= ts_r;
      mix.saa_l <= saa_l;
      mix.saa_r <= saa_r;
    end
  end

  // covox moves only right after a covox write
  assert property (@(posedge clk_28mhz) disable iff (rst)
    $changed(mix.covox) |-> $past(wr_op) == audio_pkg::port_covox);

endmodule

// ==== hw/sound_port_decode.sv ====
`include "audio_params.svh"

module sound_port_decode (
  input  logic                clk_28mhz,
  input  logic                rst,
  input  logic [15:0]         cpu_addr,
  input  logic [7:0]          cpu_data,
  input  logic                iorq_n,
  input  logic                wr_n,
  output logic                saa_wr_n,
  output logic                ts_we,
  output logic                ts_bc,
  output audio_pkg::port_op_t wr_op,
  output logic [7:0]          wr_data
);

  // I/O write in progress on the CPU bus
  logic io_wr;
  // TurboSound select, A15 high, A1 low, A0 high
  logic ts_sel;
  // operation for this bus cycle, before the register
  audio_pkg::port_op_t op_next;

  assign io_wr  = !iorq_n && !wr_n;
  assign ts_sel = cpu_addr[15] && !cpu_addr[1] && cpu_addr[0];

  // strobes to the external chips, straight from the bus
  assign saa_wr_n = !(io_wr && cpu_addr[7:0] == `SAA_PORT);
  assign ts_we    = io_wr && ts_sel;
  // BC selects address or data register on the AY pair
  assign ts_bc    = cpu_addr[14];

  // port classification by low address byte
  // the four cases never overlap, FE has A0 low, FB and FF have A1 high
  always_comb begin
    op_next = audio_pkg::port_none;
    if (io_wr) begin
      if (cpu_addr[7:0] == `BEEPER_PORT) begin
        op_next = audio_pkg::port_beeper;
      end else if (cpu_addr[7:0] == `COVOX_PORT) begin
        op_next = audio_pkg::port_covox;
      end else if (cpu_addr[7:0] == `SAA_PORT) begin
        op_next = audio_pkg::port_saa;
      end else if (ts_sel) begin
        op_next = audio_pkg::port_ts;
      end
    end
  end

  // one cycle strobe to the latch
  // a long bus write repeats the same op, which is harmless
  always_ff @(posedge clk_28mhz) begin
    if (rst) begin
      wr_op <= audio_pkg::port_none;
    end else begin
      wr_op <= op_next;
    end
  end

  // data travels alongside the op, only looked at when op is not none
  always_ff @(posedge clk_28mhz) begin
    wr_data <= cpu_data;
  end

  // an op only ever follows a bus write cycle
  assert property (@(posedge clk_28mhz) disable iff (rst)
    !$past(io_wr) |-> wr_op == audio_pkg::port_none);

  // SAA and AY pair are never written in the same cycle
  assert property (@(posedge clk_28mhz)
    !(ts_we && !saa_wr_n));

endmodule

// ==== src.f ====
+incdir+hw
hw/audio_pkg.sv
hw/mix_if.sv
hw/sound_port_decode.sv
hw/sound_latch.sv
hw/audio_mixer.sv
hw/audio_top.sv
verification/tb_clock.sv
verification/audio_tb.sv

// ==== verification/audio_tb.sv ====
`include "audio_params.svh"

module audio_tb;

  // phase lengths in clock cycles
  localparam int RST_CYCLES   = 10;
  localparam int IDLE_CYCLES  = 20;
  localparam int WRITE_CYCLES = 8;
  localparam int NUM_WRITES   = 12;
  localparam int RAND_CYCLES  = 300;
  localparam int DRAIN_CYCLES = 8;
  localparam int TEST_LEN = RST_CYCLES + IDLE_CYCLES + NUM_WRITES * WRITE_CYCLES
                          + RAND_CYCLES + DRAIN_CYCLES;
  localparam int TIMEOUT_CYCLES = 2 * TEST_LEN;

  logic                clk_28mhz;
  logic                rst;
  logic [15:0]         cpu_addr;
  logic [7:0]          cpu_data;
  logic                iorq_n;
  logic                wr_n;
  logic [`TS_W-1:0]    ts_l;
  logic [`TS_W-1:0]    ts_r;
  logic [`SAA_W-1:0]   saa_l;
  logic [`SAA_W-1:0]   saa_r;
  logic                saa_wr_n;
  logic                ts_we;
  logic                ts_bc;
  audio_pkg::sample_t  audio_l;
  audio_pkg::sample_t  audio_r;

  // model state, updated by the bus writes it sees
  logic                model_beeper;
  logic [7:0]          model_covox;
  // expected samples, three stages to line up with the DUT
  audio_pkg::sample_t  exp_l_q [0:2];
  audio_pkg::sample_t  exp_r_q [0:2];

  int audio_errors;
  int strobe_errors;
  int cycles;

  tb_clock clock_gen (
    .clk_28mhz (clk_28mhz),
    .rst       (rst)
  );

  audio_top UUT (
    .clk_28mhz (clk_28mhz),
    .rst       (rst),
    .cpu_addr  (cpu_addr),
    .cpu_data  (cpu_data),
    .iorq_n    (iorq_n),
    .wr_n      (wr_n),
    .ts_l      (ts_l),
    .ts_r      (ts_r),
    .saa_l     (saa_l),
    .saa_r     (saa_r),
    .saa_wr_n  (saa_wr_n),
    .ts_we     (ts_we),
    .ts_bc     (ts_bc),
    .audio_l   (audio_l),
    .audio_r   (audio_r)
  );

  // one side of the mix straight from the rules
  // pre-sum wraps to 16 bits, then knee on the magnitude
  function automatic audio_pkg::sample_t model_sample(input int ts, input int saa,
                                                      input int covox, input int beeper);
    int sum;
    int mag;
    int res;
    sum = (ts * 16 + saa * 64 + covox * 64 + beeper * 64) % 65536;
    if (sum >= 32768) sum = sum - 65536;
    mag = (sum < 0) ? -sum : sum;
    if (mag < `COMP_X) res = mag * `COMP_A;
    else res = (mag - `COMP_X) / `COMP_F + `COMP_X * `COMP_A;
    if (sum < 0) res = -res;
    return audio_pkg::sample_t'(res);
  endfunction

  // reference model, sees the same inputs the DUT samples at this edge
  always @(posedge clk_28mhz) begin
    if (rst) begin
      model_beeper <= 1'b0;
      model_covox  <= '0;
      exp_l_q      <= '{default: '0};
      exp_r_q      <= '{default: '0};
    end else begin
      // old beeper and covox, a write takes one more cycle to reach the mix
      exp_l_q[0] <= model_sample(ts_l, saa_l, model_covox, model_beeper);
      exp_r_q[0] <= model_sample(ts_r, saa_r, model_covox, model_beeper);
      exp_l_q[1] <= exp_l_q[0];
      exp_r_q[1] <= exp_r_q[0];
      exp_l_q[2] <= exp_l_q[1];
      exp_r_q[2] <= exp_r_q[1];
      if (!iorq_n && !wr_n) begin
        if (cpu_addr[7:0] == `COVOX_PORT) model_covox <= cpu_data;
        else if (cpu_addr[7:0] == `BEEPER_PORT) model_beeper <= cpu_data[`BEEPER_BIT];
      end
    end
  end

  check_left: assert property (@(posedge clk_28mhz) disable iff (rst)
    audio_l == exp_l_q[2])
    else begin
      audio_errors++;
      $display("error at %0t: audio_l is %0d, model gives %0d", $time,
               $sampled(audio_l), $sampled(exp_l_q[2]));
    end

  check_right: assert property (@(posedge clk_28mhz) disable iff (rst)
    audio_r == exp_r_q[2])
    else begin
      audio_errors++;
      $display("error at %0t: audio_r is %0d, model gives %0d", $time,
               $sampled(audio_r), $sampled(exp_r_q[2]));
    end

  // chip strobes follow the bus in the same cycle
  check_strobes: assert property (@(posedge clk_28mhz)
    saa_wr_n == !(!iorq_n && !wr_n && cpu_addr[7:0] == `SAA_PORT)
    && ts_we == (!iorq_n && !wr_n && cpu_addr[15] && !cpu_addr[1] && cpu_addr[0])
    && ts_bc == cpu_addr[14])
    else begin
      strobe_errors++;
      $display("error at %0t: saa_wr_n %b ts_we %b ts_bc %b for address %h", $time,
               $sampled(saa_wr_n), $sampled(ts_we), $sampled(ts_bc), $sampled(cpu_addr));
    end

  // hang guard
  always @(posedge clk_28mhz) begin
    cycles <= cycles + 1;
    if (cycles == TIMEOUT_CYCLES) begin
      $display("timeout: stimulus still running after %0d cycles", cycles);
      $display("Errors found");
      $finish;
    end
  end

  // one bus cycle, then idle long enough for the mix to settle
  task automatic bus_write(input logic [15:0] addr, input logic [7:0] data, input logic io);
    @(posedge clk_28mhz);
    cpu_addr <= addr;
    cpu_data <= data;
    iorq_n   <= !io;
    wr_n     <= 1'b0;
    @(posedge clk_28mhz);
    iorq_n <= 1'b1;
    wr_n   <= 1'b1;
    repeat (WRITE_CYCLES - 2) @(posedge clk_28mhz);
  endtask

  initial begin
    void'($urandom(32'hb770));
    // idle bus and silent chips before the first edge
    cpu_addr = '0;
    cpu_data = '0;
    iorq_n   = 1'b1;
    wr_n     = 1'b1;
    ts_l     = '0;
    ts_r     = '0;
    saa_l    = '0;
    saa_r    = '0;
    wait (rst == 1'b0);
    // silence after reset
    repeat (IDLE_CYCLES) @(posedge clk_28mhz);
    // covox below and above the knee
    bus_write({8'h00, `COVOX_PORT}, 8'h37, 1'b1);
    bus_write({8'h00, `COVOX_PORT}, 8'hff, 1'b1);
    bus_write({8'h00, `COVOX_PORT}, 8'h80, 1'b1);
    // beeper on, then off with bit 4 clear
    bus_write({8'h00, `BEEPER_PORT}, 8'h10, 1'b1);
    bus_write({8'h00, `BEEPER_PORT}, 8'hef, 1'b1);
    // SAA and both AY register selects
    bus_write({8'h00, `SAA_PORT}, 8'h5a, 1'b1);
    bus_write(16'hbffd, 8'h07, 1'b1);
    bus_write(16'hfffd, 8'h0e, 1'b1);
    // no strobe for FE, FB, or with iorq_n high
    bus_write({8'h12, `BEEPER_PORT}, 8'h10, 1'b1);
    bus_write({8'h00, `COVOX_PORT}, 8'h21, 1'b1);
    bus_write({8'h00, `SAA_PORT}, 8'h33, 1'b0);
    bus_write(16'hfffd, 8'h44, 1'b0);
    // random channels, ts above 2047 wraps the pre-sum negative
    for (int i = 0; i < RAND_CYCLES; i++) begin
      @(posedge clk_28mhz);
      ts_l  <= `TS_W'($urandom);
      ts_r  <= `TS_W'($urandom);
      saa_l <= `SAA_W'($urandom);
      saa_r <= `SAA_W'($urandom);
      if (i % 32 == 7) begin
        cpu_addr <= (i % 64 == 7) ? {8'h00, `COVOX_PORT} : {8'h00, `BEEPER_PORT};
        cpu_data <= 8'($urandom);
        iorq_n   <= 1'b0;
        wr_n     <= 1'b0;
      end else begin
        iorq_n <= 1'b1;
        wr_n   <= 1'b1;
      end
    end
    // let the last samples through the pipeline
    repeat (DRAIN_CYCLES) @(posedge clk_28mhz);
    $display("error count: audio %0d, strobe %0d", audio_errors, strobe_errors);
    if (audio_errors + strobe_errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// ==== verification/tb_clock.sv ====
// free running clock and power-on reset for the testbench
module tb_clock (
  output logic clk_28mhz,
  output logic rst
);

  // 20 time unit period
  localparam int HALF_PERIOD = 10;
  // reset held for this many rising edges
  localparam int RST_CYCLES = 10;

  initial begin
    clk_28mhz = 1'b0;
    forever #HALF_PERIOD clk_28mhz = ~clk_28mhz;
  end

  // release on a rising edge, like every other driven input
  initial begin
    rst = 1'b1;
    repeat (RST_CYCLES) @(posedge clk_28mhz);
    rst <= 1'b0;
  end

endmodule
